//--- verilog/wb_pkg.sv
package wb_pkg;

	// datapath and register file geometry
	localparam int DATA_WIDTH = 64;
	localparam int LAR_INDEX_WIDTH = 3;
	localparam int MEM_ADDR_WIDTH = 4;

	// memory access latency, counted by the ldst timer
	localparam int TIMER_WIDTH = 3;
	localparam logic [TIMER_WIDTH-1:0] LDST_LATENCY = 3'd4;

	// same numbering as the decoder groups
	typedef enum logic [1:0]
	{
		grp_alu = 2'd0,
		grp_ctrl = 2'd1,
		grp_ld = 2'd2,
		grp_st = 2'd3
	} instr_group_t;

	// loads and stores share this encoding
	typedef enum logic [3:0]
	{
		u8 = 4'd0,
		s8 = 4'd1,
		u16 = 4'd2,
		s16 = 4'd3,
		u32 = 4'd4,
		s32 = 4'd5,
		u64 = 4'd6,
		s64 = 4'd7,
		f16 = 4'd8
	} ldst_oper_t;

	typedef enum logic [1:0]
	{
		wt_only_data = 2'd0,
		wt_ld = 2'd1,
		wt_st = 2'd2
	} write_type_t;

	typedef enum logic [1:0]
	{
		dt_unsgn_int = 2'd0,
		dt_sgn_int = 2'd1,
		dt_bfloat16 = 2'd2
	} data_type_t;

	typedef enum logic [1:0]
	{
		sz8 = 2'd0,
		sz16 = 2'd1,
		sz32 = 2'd2,
		sz64 = 2'd3
	} int_size_t;

	// writeback FSM
	typedef enum logic
	{
		st_regular = 1'b0,
		st_wait_lar_valid = 1'b1
	} wb_state_t;

endpackage

//--- verilog/lar_wr_if.sv
interface lar_wr_if;

	// request side, one-cycle req with all fields valid alongside
	logic req;
	wb_pkg::write_type_t write_type;
	logic [wb_pkg::LAR_INDEX_WIDTH-1:0] index;
	wb_pkg::data_type_t data_type;
	wb_pkg::int_size_t int_size;
	logic [wb_pkg::MEM_ADDR_WIDTH-1:0] addr;
	logic [wb_pkg::DATA_WIDTH-1:0] non_ldst_data;

	// completion of a load or store
	logic valid;

	modport fsm
	(
		output req, write_type, index, data_type, int_size, addr, non_ldst_data,
		input valid
	);

	modport lar_file
	(
		input req, write_type, index, data_type, int_size, addr, non_ldst_data,
		output valid
	);

endinterface

//--- verilog/wb_stage_fsm.sv
module wb_stage_fsm
(
	input logic clk,
	input logic reset,
	input logic ex_valid,
	input wb_pkg::instr_group_t ex_group,
	input wb_pkg::ldst_oper_t ex_oper,
	input logic [wb_pkg::LAR_INDEX_WIDTH-1:0] ex_ra_index,
	input logic [wb_pkg::DATA_WIDTH-1:0] ex_computed_data,
	input logic [wb_pkg::MEM_ADDR_WIDTH-1:0] ex_ldst_addr,
	output logic ex_ready,
	lar_wr_if.fsm wr
);

	wb_pkg::wb_state_t state;
	wb_pkg::wb_state_t next_state;
	wb_pkg::data_type_t oper_data_type;
	wb_pkg::int_size_t oper_int_size;
	logic transfer;
	logic is_ldst;

	// held off for the whole load/store access
	assign ex_ready = (state == wb_pkg::st_regular);
	assign transfer = ex_valid && ex_ready;
	assign is_ldst = (ex_group == wb_pkg::grp_ld) || (ex_group == wb_pkg::grp_st);

	// opcode to type tags
	always_comb
	begin
		case (ex_oper)
		wb_pkg::u8, wb_pkg::u16, wb_pkg::u32, wb_pkg::u64:
			oper_data_type = wb_pkg::dt_unsgn_int;
		wb_pkg::s8, wb_pkg::s16, wb_pkg::s32, wb_pkg::s64:
			oper_data_type = wb_pkg::dt_sgn_int;
		wb_pkg::f16:
			oper_data_type = wb_pkg::dt_bfloat16;
		default:
			oper_data_type = wb_pkg::dt_unsgn_int;
		endcase

		case (ex_oper)
		wb_pkg::u8, wb_pkg::s8:
			oper_int_size = wb_pkg::sz8;
		wb_pkg::u16, wb_pkg::s16, wb_pkg::f16:
			oper_int_size = wb_pkg::sz16;
		wb_pkg::u32, wb_pkg::s32:
			oper_int_size = wb_pkg::sz32;
		default:
			oper_int_size = wb_pkg::sz64;
		endcase
	end

	always_comb
	begin
		case (state)
		wb_pkg::st_regular:
			next_state = (transfer && is_ldst) ? wb_pkg::st_wait_lar_valid : wb_pkg::st_regular;
		wb_pkg::st_wait_lar_valid:
			next_state = wr.valid ? wb_pkg::st_regular : wb_pkg::st_wait_lar_valid;
		default:
			next_state = wb_pkg::st_regular;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state <= wb_pkg::st_regular;
			wr.req <= 1'b0;
		end
		else
		begin
			state <= next_state;
			// group 1 is accepted but produces no write
			wr.req <= transfer && (ex_group != wb_pkg::grp_ctrl);
		end
	end

	// request fields
	always_ff @(posedge clk)
	begin
		if (transfer && (ex_group == wb_pkg::grp_alu))
		begin
			wr.write_type <= wb_pkg::wt_only_data;
			wr.index <= ex_ra_index;
			wr.non_ldst_data <= ex_computed_data;
		end
		else if (transfer && is_ldst)
		begin
			wr.write_type <= (ex_group == wb_pkg::grp_ld) ? wb_pkg::wt_ld : wb_pkg::wt_st;
			wr.index <= ex_ra_index;
			wr.addr <= ex_ldst_addr;
			wr.data_type <= oper_data_type;
			wr.int_size <= oper_int_size;
		end
	end

endmodule

//--- verilog/ldst_latency_timer.sv
module ldst_latency_timer
(
	input logic clk,
	input logic reset,
	input logic start,
	output logic done
);

	logic [wb_pkg::TIMER_WIDTH-1:0] count;

	// zero means idle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			count <= '0;
		end
		else if (start)
		begin
			count <= wb_pkg::LDST_LATENCY;
		end
		else if (count != '0)
		begin
			count <= count - 1'b1;
		end
	end

	// last cycle of the access
	assign done = (count == {{(wb_pkg::TIMER_WIDTH-1){1'b0}}, 1'b1});

endmodule

//--- verilog/lar_file.sv
module lar_file
(
	input logic clk,
	input logic reset,
	lar_wr_if.lar_file wr,
	input logic timer_done,
	output logic timer_start,
	input logic [wb_pkg::LAR_INDEX_WIDTH-1:0] rd_index,
	output logic [wb_pkg::DATA_WIDTH-1:0] rd_data,
	output logic [wb_pkg::MEM_ADDR_WIDTH-1:0] rd_addr,
	output wb_pkg::data_type_t rd_data_type,
	output wb_pkg::int_size_t rd_int_size
);

	// register file and its tags
	logic [wb_pkg::DATA_WIDTH-1:0] lar_data [2**wb_pkg::LAR_INDEX_WIDTH];
	logic [wb_pkg::MEM_ADDR_WIDTH-1:0] lar_addr [2**wb_pkg::LAR_INDEX_WIDTH];
	wb_pkg::data_type_t lar_data_type [2**wb_pkg::LAR_INDEX_WIDTH];
	wb_pkg::int_size_t lar_int_size [2**wb_pkg::LAR_INDEX_WIDTH];

	// backing memory
	logic [wb_pkg::DATA_WIDTH-1:0] mem [2**wb_pkg::MEM_ADDR_WIDTH];

	// load or store waiting on the timer
	logic pending;
	wb_pkg::write_type_t pend_type;
	logic [wb_pkg::LAR_INDEX_WIDTH-1:0] pend_index;
	logic [wb_pkg::MEM_ADDR_WIDTH-1:0] pend_addr;
	wb_pkg::data_type_t pend_data_type;
	wb_pkg::int_size_t pend_int_size;
	logic commit;

	function automatic logic [wb_pkg::DATA_WIDTH-1:0] extend_load(
		input logic [wb_pkg::DATA_WIDTH-1:0] word,
		input wb_pkg::data_type_t dt,
		input wb_pkg::int_size_t sz
	);
		logic sgn;
		logic [wb_pkg::DATA_WIDTH-1:0] result;
		sgn = (dt == wb_pkg::dt_sgn_int);
		if (dt == wb_pkg::dt_bfloat16)
		begin
			// raw bfloat16 bits in the low half-word
			result = {{(wb_pkg::DATA_WIDTH-16){1'b0}}, word[15:0]};
		end
		else
		begin
			case (sz)
			wb_pkg::sz8:
				result = {{(wb_pkg::DATA_WIDTH-8){sgn & word[7]}}, word[7:0]};
			wb_pkg::sz16:
				result = {{(wb_pkg::DATA_WIDTH-16){sgn & word[15]}}, word[15:0]};
			wb_pkg::sz32:
				result = {{(wb_pkg::DATA_WIDTH-32){sgn & word[31]}}, word[31:0]};
			default:
				result = word;
			endcase
		end
		return result;
	endfunction

	assign commit = pending && timer_done;
	assign wr.valid = commit;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			pending <= 1'b0;
			timer_start <= 1'b0;
			for (int i = 0; i < 2**wb_pkg::LAR_INDEX_WIDTH; i++)
			begin
				lar_data[i] <= '0;
				lar_addr[i] <= '0;
				lar_data_type[i] <= wb_pkg::dt_unsgn_int;
				lar_int_size[i] <= wb_pkg::sz64;
			end
			for (int i = 0; i < 2**wb_pkg::MEM_ADDR_WIDTH; i++)
			begin
				mem[i] <= '0;
			end
		end
		else
		begin
			timer_start <= 1'b0;

			if (wr.req)
			begin
				if (wr.write_type == wb_pkg::wt_only_data)
				begin
					lar_data[wr.index] <= wr.non_ldst_data;
				end
				else
				begin
					pending <= 1'b1;
					timer_start <= 1'b1;
				end
			end

			// access completes on the timer's last cycle
			if (commit)
			begin
				pending <= 1'b0;
				lar_addr[pend_index] <= pend_addr;
				lar_data_type[pend_index] <= pend_data_type;
				lar_int_size[pend_index] <= pend_int_size;
				if (pend_type == wb_pkg::wt_ld)
				begin
					lar_data[pend_index] <= extend_load(mem[pend_addr], pend_data_type,
						pend_int_size);
				end
				else
				begin
					mem[pend_addr] <= lar_data[pend_index];
				end
			end
		end
	end

	// latched request
	always_ff @(posedge clk)
	begin
		if (wr.req && (wr.write_type != wb_pkg::wt_only_data))
		begin
			pend_type <= wr.write_type;
			pend_index <= wr.index;
			pend_addr <= wr.addr;
			pend_data_type <= wr.data_type;
			pend_int_size <= wr.int_size;
		end
	end

	assign rd_data = lar_data[rd_index];
	assign rd_addr = lar_addr[rd_index];
	assign rd_data_type = lar_data_type[rd_index];
	assign rd_int_size = lar_int_size[rd_index];

endmodule

//--- verilog/wb_subsystem.sv
module wb_subsystem
(
	input logic clk,
	input logic reset,
	input logic ex_valid,
	input wb_pkg::instr_group_t ex_group,
	input wb_pkg::ldst_oper_t ex_oper,
	input logic [wb_pkg::LAR_INDEX_WIDTH-1:0] ex_ra_index,
	input logic [wb_pkg::DATA_WIDTH-1:0] ex_computed_data,
	input logic [wb_pkg::MEM_ADDR_WIDTH-1:0] ex_ldst_addr,
	output logic ex_ready,
	input logic [wb_pkg::LAR_INDEX_WIDTH-1:0] rd_index,
	output logic [wb_pkg::DATA_WIDTH-1:0] rd_data,
	output logic [wb_pkg::MEM_ADDR_WIDTH-1:0] rd_addr,
	output wb_pkg::data_type_t rd_data_type,
	output wb_pkg::int_size_t rd_int_size
);

	lar_wr_if wr_bus();

	logic timer_start;
	logic timer_done;

	wb_stage_fsm u_fsm
	(
		.clk(clk),
		.reset(reset),
		.ex_valid(ex_valid),
		.ex_group(ex_group),
		.ex_oper(ex_oper),
		.ex_ra_index(ex_ra_index),
		.ex_computed_data(ex_computed_data),
		.ex_ldst_addr(ex_ldst_addr),
		.ex_ready(ex_ready),
		.wr(wr_bus.fsm)
	);

	// models memory latency for the LAR file
	ldst_latency_timer u_timer
	(
		.clk(clk),
		.reset(reset),
		.start(timer_start),
		.done(timer_done)
	);

	lar_file u_lar_file
	(
		.clk(clk),
		.reset(reset),
		.wr(wr_bus.lar_file),
		.timer_done(timer_done),
		.timer_start(timer_start),
		.rd_index(rd_index),
		.rd_data(rd_data),
		.rd_addr(rd_addr),
		.rd_data_type(rd_data_type),
		.rd_int_size(rd_int_size)
	);

endmodule

//--- verification/wb_checker.sv
module wb_checker
(
	input logic clk,
	input logic reset,
	input logic ex_valid,
	input wb_pkg::instr_group_t ex_group,
	input logic ex_ready,
	input logic req,
	input wb_pkg::write_type_t write_type,
	input logic valid,
	input logic timer_start,
	input logic timer_done
);

	timeunit 1ns;
	timeprecision 1ps;

	int assert_failures = 0;
	logic transfer;
	logic ldst_transfer;
	logic ldst_req;
	logic ldst_outstanding;
	logic timer_busy;

	assign transfer = ex_valid && ex_ready;
	assign ldst_transfer = transfer &&
		((ex_group == wb_pkg::grp_ld) || (ex_group == wb_pkg::grp_st));
	assign ldst_req = req && (write_type != wb_pkg::wt_only_data);

	// from the load/store request until its completion
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			ldst_outstanding <= 1'b0;
		end
		else if (ldst_req)
		begin
			ldst_outstanding <= 1'b1;
		end
		else if (valid)
		begin
			ldst_outstanding <= 1'b0;
		end
	end

	// count running between start and done
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			timer_busy <= 1'b0;
		end
		else if (timer_start)
		begin
			timer_busy <= 1'b1;
		end
		else if (timer_done)
		begin
			timer_busy <= 1'b0;
		end
	end

	a_ready_after_reset: assert property (@(posedge clk) reset |=> ex_ready)
	else
	begin
		$error("ex_ready not high after reset");
		assert_failures++;
	end

	a_ldst_req_pulse: assert property (@(posedge clk) disable iff (reset) ldst_req |=> !req)
	else
	begin
		$error("load/store req longer than one cycle");
		assert_failures++;
	end

	a_valid_needs_pending: assert property (@(posedge clk) disable iff (reset)
		valid |-> ldst_outstanding)
	else
	begin
		$error("valid without a pending load or store");
		assert_failures++;
	end

	a_ready_falls: assert property (@(posedge clk) disable iff (reset) ldst_transfer |=> !ex_ready)
	else
	begin
		$error("ex_ready not low after a load/store transfer");
		assert_failures++;
	end

	a_ready_held: assert property (@(posedge clk) disable iff (reset)
		(!ex_ready && !valid) |=> !ex_ready)
	else
	begin
		$error("ex_ready rose before valid");
		assert_failures++;
	end

	a_start_when_idle: assert property (@(posedge clk) disable iff (reset)
		timer_start |-> !timer_busy)
	else
	begin
		$error("timer start while a count is running");
		assert_failures++;
	end

endmodule

// watches the FSM side and the LAR file side together
bind wb_subsystem wb_checker u_checker
(
	.clk(clk),
	.reset(reset),
	.ex_valid(ex_valid),
	.ex_group(ex_group),
	.ex_ready(ex_ready),
	.req(wr_bus.req),
	.write_type(wr_bus.write_type),
	.valid(wr_bus.valid),
	.timer_start(timer_start),
	.timer_done(timer_done)
);

//--- verification/tb_wb_subsystem.sv
module tb_wb_subsystem;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT_CYCLES = 40;
	localparam int NUM_LARS = 2**wb_pkg::LAR_INDEX_WIDTH;
	localparam int NUM_WORDS = 2**wb_pkg::MEM_ADDR_WIDTH;

	logic clk;
	logic reset;
	logic ex_valid;
	wb_pkg::instr_group_t ex_group;
	wb_pkg::ldst_oper_t ex_oper;
	logic [wb_pkg::LAR_INDEX_WIDTH-1:0] ex_ra_index;
	logic [wb_pkg::DATA_WIDTH-1:0] ex_computed_data;
	logic [wb_pkg::MEM_ADDR_WIDTH-1:0] ex_ldst_addr;
	logic ex_ready;
	logic [wb_pkg::LAR_INDEX_WIDTH-1:0] rd_index;
	logic [wb_pkg::DATA_WIDTH-1:0] rd_data;
	logic [wb_pkg::MEM_ADDR_WIDTH-1:0] rd_addr;
	wb_pkg::data_type_t rd_data_type;
	wb_pkg::int_size_t rd_int_size;

	// reference model of the LARs and the memory
	logic [wb_pkg::DATA_WIDTH-1:0] m_data [NUM_LARS];
	logic [wb_pkg::MEM_ADDR_WIDTH-1:0] m_addr [NUM_LARS];
	wb_pkg::data_type_t m_dt [NUM_LARS];
	wb_pkg::int_size_t m_sz [NUM_LARS];
	logic [wb_pkg::DATA_WIDTH-1:0] m_mem [NUM_WORDS];

	int seed;

	wb_subsystem uut
	(
		.clk(clk),
		.reset(reset),
		.ex_valid(ex_valid),
		.ex_group(ex_group),
		.ex_oper(ex_oper),
		.ex_ra_index(ex_ra_index),
		.ex_computed_data(ex_computed_data),
		.ex_ldst_addr(ex_ldst_addr),
		.ex_ready(ex_ready),
		.rd_index(rd_index),
		.rd_data(rd_data),
		.rd_addr(rd_addr),
		.rd_data_type(rd_data_type),
		.rd_int_size(rd_int_size)
	);

	initial clk = 1'b0;
	always #5 clk = ~clk;

	task automatic abort(input string reason);
		$display("Result: FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic value_error(input string name, input string what,
		input logic [63:0] expected, input logic [63:0] actual);
		$display("[ERROR] %s: %s expected %h, actual %h", name, what, expected, actual);
		abort("read port mismatch");
	endtask

	// failure count of the bound protocol checker
	always @(negedge clk)
	begin
		if (uut.u_checker.assert_failures != 0)
		begin
			$display("A protocol assertion in the bound checker failed");
			abort("protocol assertion");
		end
	end

	function automatic wb_pkg::data_type_t oper_data_type(input wb_pkg::ldst_oper_t op);
		case (op)
		wb_pkg::s8, wb_pkg::s16, wb_pkg::s32, wb_pkg::s64: return wb_pkg::dt_sgn_int;
		wb_pkg::f16: return wb_pkg::dt_bfloat16;
		default: return wb_pkg::dt_unsgn_int;
		endcase
	endfunction

	function automatic wb_pkg::int_size_t oper_int_size(input wb_pkg::ldst_oper_t op);
		case (op)
		wb_pkg::u8, wb_pkg::s8: return wb_pkg::sz8;
		wb_pkg::u16, wb_pkg::s16, wb_pkg::f16: return wb_pkg::sz16;
		wb_pkg::u32, wb_pkg::s32: return wb_pkg::sz32;
		default: return wb_pkg::sz64;
		endcase
	endfunction

	// masks the loaded width, then fills the top with the sign when signed
	function automatic logic [63:0] load_value(input logic [63:0] word,
		input wb_pkg::ldst_oper_t op);
		int bits;
		logic [63:0] mask;
		logic [63:0] result;
		bits = 8 << oper_int_size(op);
		mask = (bits == 64) ? '1 : ((64'd1 << bits) - 64'd1);
		result = word & mask;
		if ((oper_data_type(op) == wb_pkg::dt_sgn_int) && word[bits-1])
		begin
			result = result | ~mask;
		end
		return result;
	endfunction

	task automatic model_apply(input wb_pkg::instr_group_t g, input wb_pkg::ldst_oper_t op,
		input int idx, input logic [63:0] data, input int addr);
		case (g)
		wb_pkg::grp_alu:
			m_data[idx] = data;
		wb_pkg::grp_ld:
		begin
			m_data[idx] = load_value(m_mem[addr], op);
			m_addr[idx] = 4'(addr);
			m_dt[idx] = oper_data_type(op);
			m_sz[idx] = oper_int_size(op);
		end
		wb_pkg::grp_st:
		begin
			m_mem[addr] = m_data[idx];
			m_addr[idx] = 4'(addr);
			m_dt[idx] = oper_data_type(op);
			m_sz[idx] = oper_int_size(op);
		end
		default:
		begin
		end
		endcase
	endtask

	// called just after a rising edge; returns just after the transfer edge
	task automatic issue(input wb_pkg::instr_group_t g, input wb_pkg::ldst_oper_t op,
		input int idx, input logic [63:0] data, input int addr, output int stalled);
		ex_valid <= 1'b1;
		ex_group <= g;
		ex_oper <= op;
		ex_ra_index <= 3'(idx);
		ex_computed_data <= data;
		ex_ldst_addr <= 4'(addr);
		stalled = 0;
		@(negedge clk);
		while (!ex_ready)
		begin
			stalled++;
			if (stalled > TIMEOUT_CYCLES)
			begin
				$display("Timeout: instruction was never accepted by the writeback stage");
				abort("timeout");
			end
			@(negedge clk);
		end
		@(posedge clk);
		model_apply(g, op, idx, data, addr);
	endtask

	// drop valid and wait until the last write has landed
	task automatic settle();
		int cycles;
		ex_valid <= 1'b0;
		cycles = 0;
		@(negedge clk);
		while (!ex_ready)
		begin
			cycles++;
			if (cycles > TIMEOUT_CYCLES)
			begin
				$display("Timeout: ex_ready never came back after a load or store");
				abort("timeout");
			end
			@(negedge clk);
		end
		@(posedge clk);
	endtask

	task automatic check_reg(input string name, input int idx);
		rd_index <= 3'(idx);
		@(negedge clk);
		assert (ex_ready)
		else value_error(name, "ex_ready", 64'd1, 64'(ex_ready));
		assert (rd_data == m_data[idx])
		else value_error(name, $sformatf("LAR %0d data", idx), m_data[idx], rd_data);
		assert (rd_addr == m_addr[idx])
		else value_error(name, $sformatf("LAR %0d addr", idx), 64'(m_addr[idx]), 64'(rd_addr));
		assert (rd_data_type == m_dt[idx])
		else value_error(name, $sformatf("LAR %0d data type", idx), 64'(m_dt[idx]),
			64'(rd_data_type));
		assert (rd_int_size == m_sz[idx])
		else value_error(name, $sformatf("LAR %0d int size", idx), 64'(m_sz[idx]),
			64'(rd_int_size));
		@(posedge clk);
	endtask

	initial
	begin
		int stalled;
		int gap;
		int idx;
		logic [63:0] pattern;
		wb_pkg::instr_group_t g;
		wb_pkg::ldst_oper_t op;

		seed = 48;
		reset = 1'b1;
		ex_valid = 1'b0;
		ex_group = wb_pkg::grp_alu;
		ex_oper = wb_pkg::u8;
		ex_ra_index = '0;
		ex_computed_data = '0;
		ex_ldst_addr = '0;
		rd_index = '0;
		for (int i = 0; i < NUM_LARS; i++)
		begin
			m_data[i] = '0;
			m_addr[i] = '0;
			m_dt[i] = wb_pkg::dt_unsgn_int;
			m_sz[i] = wb_pkg::sz64;
		end
		for (int i = 0; i < NUM_WORDS; i++)
		begin
			m_mem[i] = '0;
		end

		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		for (int i = 0; i < NUM_LARS; i++)
		begin
			check_reg("reset", i);
		end

		// back-to-back ALU writes, some indices repeated
		for (int k = 0; k < 10; k++)
		begin
			issue(wb_pkg::grp_alu, wb_pkg::u8, (k * 3) % 5, {$random(seed), $random(seed)}, 0,
				stalled);
		end
		settle();
		for (int i = 0; i < NUM_LARS; i++)
		begin
			check_reg("alu burst", i);
		end

		// sign bits set at 8, 16, 32 and 64 bits
		pattern = 64'hF123_4567_C789_A0BC;
		issue(wb_pkg::grp_alu, wb_pkg::u8, 1, pattern, 0, stalled);
		issue(wb_pkg::grp_st, wb_pkg::s16, 1, 64'd0, 9, stalled);
		settle();
		check_reg("store", 1);
		for (int k = 0; k < 9; k++)
		begin
			op = wb_pkg::ldst_oper_t'(4'(k));
			issue(wb_pkg::grp_ld, op, (k % 6) + 2, 64'd0, 9, stalled);
			settle();
			check_reg($sformatf("load %s", op.name()), (k % 6) + 2);
		end

		// ALU held behind a load to the same LAR
		issue(wb_pkg::grp_ld, wb_pkg::s8, 4, 64'd0, 9, stalled);
		issue(wb_pkg::grp_alu, wb_pkg::u8, 4, 64'h0BAD_F00D_1234_5678, 0, stalled);
		assert (stalled > 0)
		else
		begin
			$display("The ALU instruction was accepted while a load was in flight");
			abort("no back-pressure");
		end
		settle();
		check_reg("back-pressure", 4);

		// group 1 is taken and dropped
		issue(wb_pkg::grp_ctrl, wb_pkg::u64, 2, 64'hDEAD_BEEF_DEAD_BEEF, 3, stalled);
		issue(wb_pkg::grp_ctrl, wb_pkg::s32, 5, 64'h1111_2222_3333_4444, 7, stalled);
		ex_valid <= 1'b0;
		@(negedge clk);
		assert ((stalled == 0) && ex_ready)
		else
		begin
			$display("ex_ready went low after a group 1 instruction");
			abort("group 1 stall");
		end
		@(posedge clk);
		check_reg("group 1", 2);
		check_reg("group 1", 5);

		for (int n = 0; n < 200; n++)
		begin
			g = wb_pkg::instr_group_t'(2'($random(seed)));
			op = wb_pkg::ldst_oper_t'(4'($unsigned($random(seed)) % 9));
			idx = $unsigned($random(seed)) % NUM_LARS;
			gap = $unsigned($random(seed)) % 3;
			issue(g, op, idx, {$random(seed), $random(seed)},
				$unsigned($random(seed)) % NUM_WORDS, stalled);
			settle();
			check_reg($sformatf("random %0d", n), idx);
			repeat (gap) @(posedge clk);
		end
		for (int i = 0; i < NUM_LARS; i++)
		begin
			check_reg("final sweep", i);
		end

		$display("Result: PASSED");
		$finish;
	end

endmodule

//--- flist.f
verilog/wb_pkg.sv
verilog/lar_wr_if.sv
verilog/wb_stage_fsm.sv
verilog/ldst_latency_timer.sv
verilog/lar_file.sv
verilog/wb_subsystem.sv
verification/wb_checker.sv
verification/tb_wb_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the writeback testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_wb_subsystem -Mdir obj_dir -f flist.f \
	&& ./obj_dir/Vtb_wb_subsystem | tee /dev/stderr | grep -q "Result: PASSED" \
	&& echo "simulation passed" \
	|| { echo "simulation failed"; exit 1; }
